/* Makefile */
VERILATOR  = verilator
TOP        = tb_uart_cmd_bridge
FILELIST   = tb.f
BUILD_DIR  = obj_dir
SIM_FLAGS  = --binary --timing --assert --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS = --lint-only --timing --assert --top-module $(TOP)
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# the run passes only when the pass line shows up in the output.
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* src/cmd_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo
  import uart_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
) (
  input  wire  clk,
  input  wire  rst_n,
  input  cmd_t in_data,
  input  wire  in_valid,
  output logic in_ready,
  output cmd_t out_data,
  output logic out_valid,
  input  wire  out_ready
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

  cmd_t             mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  // a full FIFO still takes a word when one leaves in the same cycle.
  assign in_ready  = (count != CNT_FULL) || out_ready;

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;  // wrap for any depth.
      end
      if (pop)
      begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop)
      begin
        count <= count + 1'b1;
      end
      else if (pop && !push)
      begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge
  import uart_pkg::*;
#(
  parameter int BAUD_DIV   = 434,
  parameter int FIFO_DEPTH = 4
) (
  input  wire  clk,
  input  wire  rst_n,
  input  cmd_t cmd_data,
  input  wire  cmd_valid,
  output logic cmd_ready,
  output rsp_t rsp_data,
  output logic rsp_valid,
  input  wire  rsp_ready,
  input  wire  rx,
  output logic tx
);

  cmd_t  q_data;
  logic  q_valid;
  logic  q_ready;
  byte_t tx_byte;
  logic  tx_start;
  logic  tx_busy;
  byte_t rx_byte;
  logic  rx_valid;
  logic  rx_parity_err;
  logic  rx_start_seen;

  cmd_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (cmd_data),
    .in_valid  (cmd_valid),
    .in_ready  (cmd_ready),
    .out_data  (q_data),
    .out_valid (q_valid),
    .out_ready (q_ready)
  );

  uart_cmd_engine #(
    .BAUD_DIV (BAUD_DIV)
  ) u_engine (
    .clk           (clk),
    .rst_n         (rst_n),
    .q_data        (q_data),
    .q_valid       (q_valid),
    .q_ready       (q_ready),
    .tx_byte       (tx_byte),
    .tx_start      (tx_start),
    .tx_busy       (tx_busy),
    .rx_byte       (rx_byte),
    .rx_valid      (rx_valid),
    .rx_parity_err (rx_parity_err),
    .rx_start_seen (rx_start_seen),
    .rsp_data      (rsp_data),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready)
  );

  uart_tx_frame #(
    .BAUD_DIV (BAUD_DIV)
  ) u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .data  (tx_byte),
    .start (tx_start),
    .busy  (tx_busy),
    .tx    (tx)
  );

  uart_rx_frame #(
    .BAUD_DIV (BAUD_DIV)
  ) u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rx         (rx),
    .data       (rx_byte),
    .valid      (rx_valid),
    .parity_err (rx_parity_err),
    .start_seen (rx_start_seen)
  );

endmodule

`default_nettype wire

/* src/uart_cmd_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_engine
  import uart_pkg::*;
#(
  parameter int BAUD_DIV = 434
) (
  input  wire   clk,
  input  wire   rst_n,
  input  cmd_t  q_data,
  input  wire   q_valid,
  output logic  q_ready,
  output byte_t tx_byte,
  output logic  tx_start,
  input  wire   tx_busy,
  input  byte_t rx_byte,
  input  wire   rx_valid,
  input  wire   rx_parity_err,
  input  wire   rx_start_seen,
  output rsp_t  rsp_data,
  output logic  rsp_valid,
  input  wire   rsp_ready
);

  localparam int BW = $clog2(BAUD_DIV + 1);
  localparam int TW = $clog2((RESP_TIMEOUT > GAP_BITS) ? RESP_TIMEOUT : GAP_BITS) + 1;
  localparam logic [BW-1:0] BAUD_LAST = BW'(BAUD_DIV - 1);
  localparam logic [TW-1:0] GAP_LAST  = TW'(GAP_BITS - 1);
  localparam logic [TW-1:0] TO_LAST   = TW'(RESP_TIMEOUT - 1);

  engine_state_t state;
  engine_state_t state_d;
  cmd_t          cmd_q;
  logic [BW-1:0] baud_cnt;
  logic [TW-1:0] bit_cnt;
  logic          baud_tick;
  logic          busy_d;
  logic          tx_done;
  logic          got_start;
  logic          timeout_hit;
  logic          launch;

  assign q_ready     = (state == IDLE) && q_valid;
  assign rsp_valid   = (state == RESPOND);
  assign baud_tick   = (baud_cnt == BAUD_LAST);
  assign tx_done     = busy_d && !tx_busy;  // serializer just finished.
  assign timeout_hit = !got_start && baud_tick && (bit_cnt == TO_LAST);
  assign launch      = (state_d != state) && (state_d == SEND_HI || state_d == SEND_LO);

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d = state;
    case (state)
      IDLE:       if (q_valid) state_d = DECODE;
      DECODE:     if (!tx_busy) state_d = SEND_HI;
      SEND_HI:
      begin
        if (tx_done)
        begin
          state_d = cmd_q[CMD_WRITE_BIT] ? GAP : WAIT_REPLY;
        end
      end
      GAP:        if (baud_tick && bit_cnt == GAP_LAST) state_d = SEND_LO;
      SEND_LO:    if (tx_done) state_d = IDLE;
      WAIT_REPLY: if (rx_valid || timeout_hit) state_d = RESPOND;
      RESPOND:    if (rsp_ready) state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      tx_start  <= 1'b0;
      busy_d    <= 1'b0;
      got_start <= 1'b0;
    end
    else
    begin
      state    <= state_d;
      tx_start <= launch;  // one cycle, the serializer is free here.
      busy_d   <= tx_busy;
      if (state != WAIT_REPLY)
      begin
        got_start <= 1'b0;
      end
      else if (rx_start_seen)
      begin
        got_start <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bit-time counter for gap and reply timeout
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (state != GAP && state != WAIT_REPLY)
    begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (baud_tick)
    begin
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // command, byte and response registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (q_ready)
    begin
      cmd_q <= q_data;
    end
    if (launch)
    begin
      tx_byte <= (state_d == SEND_HI) ? cmd_q[15:8] : cmd_q[7:0];
    end
    if (state == WAIT_REPLY)
    begin
      if (rx_valid)
      begin
        rsp_data <= '{data: rx_byte, parity_err: rx_parity_err, timeout: 1'b0};
      end
      else if (timeout_hit)
      begin
        rsp_data <= '{data: '0, parity_err: 1'b0, timeout: 1'b1};  // no reply.
      end
    end
  end

endmodule

`default_nettype wire

/* src/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  //////////////////////////////////////////////////////////////////////
  // word and byte types
  //////////////////////////////////////////////////////////////////////

  typedef logic [15:0] cmd_t;   // bit 15 selects write, [15:8] upper, [7:0] lower.
  typedef logic [7:0]  byte_t;

  // response returned for every read command.
  typedef struct packed {
    byte_t data;
    logic  parity_err;
    logic  timeout;
  } rsp_t;

  //////////////////////////////////////////////////////////////////////
  // command engine states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    DECODE,
    SEND_HI,
    GAP,
    SEND_LO,
    WAIT_REPLY,
    RESPOND
  } engine_state_t;

  //////////////////////////////////////////////////////////////////////
  // frame and timing constants
  //////////////////////////////////////////////////////////////////////

  localparam int GAP_BITS      = 16;  // write gap, in bit times.
  localparam int RESP_TIMEOUT  = 32;  // reply start window, in bit times.
  localparam int FRAME_BITS    = 11;  // start, 8 data, parity, stop.
  localparam int CMD_WRITE_BIT = 15;

endpackage

`default_nettype wire

/* src/uart_rx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx_frame
  import uart_pkg::*;
#(
  parameter int BAUD_DIV = 434
) (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   rx,
  output byte_t data,
  output logic  valid,
  output logic  parity_err,
  output logic  start_seen
);

  localparam int BW = $clog2(BAUD_DIV + 1);
  localparam logic [BW-1:0] HALF_LAST = BW'(BAUD_DIV / 2 - 1);
  localparam logic [BW-1:0] BAUD_LAST = BW'(BAUD_DIV - 1);
  localparam logic [3:0]    PAR_IDX   = 4'(FRAME_BITS - 2);
  localparam logic [3:0]    STOP_IDX  = 4'(FRAME_BITS - 1);

  logic [1:0]    sync;
  logic          rx_s;
  logic          rx_d;
  logic          active;
  logic [3:0]    bit_idx;   // 0 is the start bit.
  logic [BW-1:0] baud_cnt;
  logic          sample;
  byte_t         shreg;
  logic          par_bit;

  assign rx_s   = sync[1];
  assign data   = shreg;
  assign sample = (bit_idx == '0) ? (baud_cnt == HALF_LAST) : (baud_cnt == BAUD_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync <= 2'b11;  // line idles high.
      rx_d <= 1'b1;
    end
    else
    begin
      sync <= {sync[0], rx};
      rx_d <= rx_s;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data and parity capture at bit centers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (active && sample)
    begin
      if (bit_idx != '0 && bit_idx < PAR_IDX)
      begin
        shreg <= {rx_s, shreg[7:1]};
      end
      if (bit_idx == PAR_IDX)
      begin
        par_bit <= rx_s;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // frame sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active     <= 1'b0;
      bit_idx    <= '0;
      baud_cnt   <= '0;
      valid      <= 1'b0;
      parity_err <= 1'b0;
      start_seen <= 1'b0;
    end
    else
    begin
      valid      <= 1'b0;
      start_seen <= 1'b0;
      if (!active)
      begin
        if (rx_d && !rx_s)  // falling edge.
        begin
          active   <= 1'b1;
          bit_idx  <= '0;
          baud_cnt <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        if (bit_idx == '0)
        begin
          if (rx_s)
          begin
            active <= 1'b0;  // glitch, not a start bit.
          end
          else
          begin
            start_seen <= 1'b1;
            bit_idx    <= bit_idx + 1'b1;
          end
        end
        else if (bit_idx == STOP_IDX)
        begin
          valid      <= 1'b1;
          parity_err <= (par_bit != ^shreg) || !rx_s;  // low stop is an error too.
          active     <= 1'b0;
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/uart_tx_frame.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx_frame
  import uart_pkg::*;
#(
  parameter int BAUD_DIV = 434
) (
  input  wire   clk,
  input  wire   rst_n,
  input  byte_t data,
  input  wire   start,
  output logic  busy,
  output logic  tx
);

  localparam int BW = $clog2(BAUD_DIV + 1);
  localparam logic [BW-1:0] BAUD_LAST = BW'(BAUD_DIV - 1);
  localparam logic [3:0]    BIT_LAST  = 4'(FRAME_BITS - 1);

  logic [BW-1:0]         baud_cnt;
  logic [3:0]            bit_cnt;
  logic [FRAME_BITS-2:0] shreg;   // bits still to go after the start bit.
  logic                  take;

  assign take = start && !busy;

  //////////////////////////////////////////////////////////////////////
  // shift register, lsb goes out first
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      shreg <= {1'b1, ^data, data};  // stop, even parity, data.
    end
    else if (busy && baud_cnt == BAUD_LAST)
    begin
      shreg <= shreg >> 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // baud and bit counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (take)
    begin
      busy     <= 1'b1;
      tx       <= 1'b0;  // start bit.
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (busy)
    begin
      if (baud_cnt == BAUD_LAST)
      begin
        baud_cnt <= '0;
        if (bit_cnt == BIT_LAST)
        begin
          busy <= 1'b0;  // stop bit done, line stays high.
          tx   <= 1'b1;
        end
        else
        begin
          tx      <= shreg[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* tb.f */
src/uart_pkg.sv
src/cmd_fifo.sv
src/uart_tx_frame.sv
src/uart_rx_frame.sv
src/uart_cmd_engine.sv
src/uart_cmd_bridge.sv
testbench/uart_cmd_bridge_props.sv
testbench/tb_uart_cmd_bridge.sv

/* testbench/cmd_vectors.txt */
// columns: command word, reply byte, reply mode (0 good, 1 bad parity, 2 no reply), in hex.
// writes set bit 15 and keep the reply columns at zero.
a53c 00 0
1200 5a 0
8001 00 0
2377 c3 1
3400 00 2
ff00 00 0
0f11 81 0
7e00 00 2
9966 00 0
4c00 ff 1
5500 00 0
c0de 00 0
6100 3c 0
e7e7 00 0

/* testbench/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge
  import uart_pkg::*;
();

  localparam int BAUD_DIV   = 16;
  localparam int FIFO_DEPTH = 4;
  localparam int CLK_PERIOD = 100;
  localparam int MAX_VEC    = 16;

  logic clk;
  logic rst_n;
  cmd_t cmd_data;
  logic cmd_valid;
  logic cmd_ready;
  rsp_t rsp_data;
  logic rsp_valid;
  logic rsp_ready;
  logic rx;
  logic tx;

  logic [31:0] vec_mem [0:3*MAX_VEC-1];
  cmd_t        vec_cmd[$];
  byte_t       vec_reply[$];
  logic [1:0]  vec_mode[$];
  int          exp_frames[$];  // vector index * 2, plus one for a lower byte.
  rsp_t        exp_rsp[$];
  int          reply_q[$];
  int          nvec;
  int          cyc;
  int          frame_errs;
  int          rsp_errs;
  int          other_errs;
  logic        saw_full;

  uart_cmd_bridge #(
    .BAUD_DIV   (BAUD_DIV),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_data  (cmd_data),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp_data  (rsp_data),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rx        (rx),
    .tx        (tx)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  //////////////////////////////////////////////////////////////////////
  // expected values from the frame and response rules
  //////////////////////////////////////////////////////////////////////

  function automatic rsp_t expected_rsp(input byte_t reply, input logic [1:0] mode);
    rsp_t r;
    r.timeout    = (mode == 2'd2);
    r.parity_err = (mode == 2'd1);
    r.data       = r.timeout ? 8'h00 : reply;  // a timeout carries zero data.
    return r;
  endfunction

  task automatic print_error_counts();
    $display("errors: frame %0d, response %0d, other %0d, assertion %0d",
             frame_errs, rsp_errs, other_errs, uut.u_props.fail_count);
  endtask

  // samples at negedge, so each bit is read mid-cycle near its center.
  task automatic read_tx_frame(output byte_t data, output logic par, output logic stop,
                               output logic start_ok);
    repeat (BAUD_DIV / 2) @(negedge clk);
    start_ok = (tx === 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (BAUD_DIV) @(negedge clk);
      data[i] = tx;
    end
    repeat (BAUD_DIV) @(negedge clk);
    par = tx;
    repeat (BAUD_DIV) @(negedge clk);
    stop = tx;
  endtask

  task automatic drive_rx_frame(input byte_t data, input logic bad_parity);
    logic [FRAME_BITS-1:0] bits;
    bits = {1'b1, (^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (BAUD_DIV) @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // line model: tx monitor and rx responder
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    byte_t data;
    byte_t exp_byte;
    logic  par;
    logic  stop;
    logic  start_ok;
    logic  lo;
    int    f;
    int    idx;
    int    start_cyc;
    int    hi_start;
    int    idle;
    hi_start = 0;
    @(posedge rst_n);
    forever
    begin
      @(negedge clk);
      if (tx === 1'b0)
      begin
        start_cyc = cyc;
        read_tx_frame(data, par, stop, start_ok);
        if (!start_ok)
        begin
          other_errs++;
          $display("tx went low but the start bit did not hold to its center");
        end
        else if (exp_frames.size() == 0)
        begin
          other_errs++;
          $display("frame with byte %h on tx while none was expected", data);
        end
        else
        begin
          f        = exp_frames.pop_front();
          idx      = f / 2;
          lo       = (f % 2) == 1;
          exp_byte = lo ? vec_cmd[idx][7:0] : vec_cmd[idx][15:8];
          if (data !== exp_byte)
          begin
            frame_errs++;
            $display("error tx data: got %h expected %h", data, exp_byte);
          end
          if (par !== ^data)
          begin
            frame_errs++;
            $display("error tx parity: got %h expected %h", par, ^data);
          end
          if (stop !== 1'b1)
          begin
            frame_errs++;
            $display("error tx stop: got %h expected %h", stop, 1'b1);
          end
          if (!vec_cmd[idx][CMD_WRITE_BIT])
          begin
            reply_q.push_back(idx);  // read, so answer on rx.
          end
          else if (!lo)
          begin
            hi_start = start_cyc;
          end
          else
          begin
            idle = start_cyc - hi_start - FRAME_BITS * BAUD_DIV;
            if (idle < GAP_BITS * BAUD_DIV - 2 || idle > GAP_BITS * BAUD_DIV + 2)
            begin
              frame_errs++;
              $display("error tx gap: got %h expected %h +/- 2", idle, GAP_BITS * BAUD_DIV);
            end
          end
        end
      end
    end
  end

  initial
  begin
    int idx;
    rx = 1'b1;
    forever
    begin
      @(posedge clk);
      if (reply_q.size() != 0)
      begin
        idx = reply_q.pop_front();
        repeat (2 * BAUD_DIV) @(posedge clk);  // reply well inside the window.
        #1;
        if (vec_mode[idx] != 2'd2)
        begin
          drive_rx_frame(vec_reply[idx], vec_mode[idx] == 2'd1);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side: random back-pressure and checker
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(32'he18a));
    rsp_ready = 1'b0;
    @(posedge rst_n);
    forever
    begin
      @(posedge clk);
      #1;
      rsp_ready = ($urandom_range(3) == 0) ? 1'b1 : 1'b0;  // mostly stalled.
    end
  end

  always @(negedge clk)
  begin
    rsp_t exp;
    if (rst_n && !cmd_ready)
    begin
      saw_full = 1'b1;
    end
    if (rst_n && rsp_valid && rsp_ready)
    begin
      if (exp_rsp.size() == 0)
      begin
        other_errs++;
        $display("response %h arrived while none was expected", rsp_data);
      end
      else
      begin
        exp = exp_rsp.pop_front();
        if (rsp_data !== exp)
        begin
          rsp_errs++;
          $display("error rsp_data: got %h expected %h", rsp_data, exp);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // vectors, reset, command driver and final report
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    cmd_data   = '0;
    cmd_valid  = 1'b0;
    cyc        = 0;
    frame_errs = 0;
    rsp_errs   = 0;
    other_errs = 0;
    saw_full   = 1'b0;
    for (int a = 0; a < 3 * MAX_VEC; a++)
    begin
      vec_mem[a] = {16'hdead, 16'(a)};  // upper half nonzero marks an unused entry.
    end
    $readmemh("testbench/cmd_vectors.txt", vec_mem);
    nvec = 0;
    while (nvec < MAX_VEC && vec_mem[3 * nvec][31:16] == 16'h0000)
    begin
      vec_cmd.push_back(vec_mem[3 * nvec][15:0]);
      vec_reply.push_back(vec_mem[3 * nvec + 1][7:0]);
      vec_mode.push_back(vec_mem[3 * nvec + 2][1:0]);
      exp_frames.push_back(2 * nvec);
      if (vec_mem[3 * nvec][CMD_WRITE_BIT])
      begin
        exp_frames.push_back(2 * nvec + 1);
      end
      else
      begin
        exp_rsp.push_back(expected_rsp(vec_mem[3 * nvec + 1][7:0], vec_mem[3 * nvec + 2][1:0]));
      end
      nvec++;
    end
    if (nvec == 0)
    begin
      other_errs++;
      $display("no vectors were read from the vector file");
    end

    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    @(negedge clk);
    if (tx !== 1'b1)
    begin
      other_errs++;
      $display("error tx: got %h expected %h", tx, 1'b1);
    end
    if (rsp_valid !== 1'b0)
    begin
      other_errs++;
      $display("error rsp_valid: got %h expected %h", rsp_valid, 1'b0);
    end
    if (cmd_ready !== 1'b1)
    begin
      other_errs++;
      $display("error cmd_ready: got %h expected %h", cmd_ready, 1'b1);
    end

    @(posedge clk);
    #1;
    for (int i = 0; i < nvec; i++)
    begin
      cmd_data  = vec_cmd[i];
      cmd_valid = 1'b1;
      do
      begin
        @(negedge clk);
      end
      while (cmd_ready !== 1'b1);
      @(posedge clk);
      #1;
    end
    cmd_valid = 1'b0;

    while (exp_frames.size() != 0 || exp_rsp.size() != 0)
    begin
      @(posedge clk);
    end
    repeat (4 * BAUD_DIV) @(negedge clk);  // room for a stray frame or response.
    if (tx !== 1'b1 || rsp_valid !== 1'b0)
    begin
      other_errs++;
      $display("bridge not idle after the last command");
    end
    if (!saw_full)
    begin
      other_errs++;
      $display("cmd_ready never fell, so the FIFO never filled");
    end

    print_error_counts();
    if (frame_errs + rsp_errs + other_errs + uut.u_props.fail_count == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, twice the worst case per command.
  initial
  begin
    longint limit_ns;
    @(posedge rst_n);
    limit_ns = longint'(nvec) * (3 * FRAME_BITS + GAP_BITS + RESP_TIMEOUT) * BAUD_DIV
               * CLK_PERIOD * 2;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    print_error_counts();
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/uart_cmd_bridge_props.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge_props
  import uart_pkg::*;
#(
  parameter int FIFO_DEPTH = 4,
  parameter int CNT_W      = $clog2(FIFO_DEPTH + 1)
) (
  input wire  clk,
  input wire  rst_n,
  input rsp_t rsp_data,
  input wire  rsp_valid,
  input wire  rsp_ready,
  input wire  cmd_valid,
  input wire  cmd_ready,
  input wire  q_valid,
  input wire  q_ready,
  input wire  tx
);

  int               fail_count = 0;
  logic [CNT_W-1:0] occupancy;  // commands held, counted from both handshakes.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      occupancy <= '0;
    end
    else
    begin
      occupancy <= occupancy + CNT_W'(cmd_valid && cmd_ready) - CNT_W'(q_valid && q_ready);
    end
  end

  // response held while the consumer stalls.
  rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
  else
  begin
    fail_count++;
    $error("rsp_data or rsp_valid changed under back-pressure");
  end

  tx_idle_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> tx)
  else
  begin
    fail_count++;
    $error("tx not high after reset");
  end

  ready_low_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    !cmd_ready |-> occupancy == CNT_W'(FIFO_DEPTH))
  else
  begin
    fail_count++;
    $error("cmd_ready low while the FIFO has room");
  end

endmodule

bind uart_cmd_bridge uart_cmd_bridge_props #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .rsp_data   (rsp_data),
  .rsp_valid  (rsp_valid),
  .rsp_ready  (rsp_ready),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .q_valid    (q_valid),
  .q_ready    (q_ready),
  .tx         (tx)
);

`default_nettype wire
